//--- source/tankPkg.sv
`default_nettype none

package tankPkg;

    // Screen coordinate in pixels
    typedef logic [9:0] coordT;

    // Half-width of a square; also used for step size and bounce limit
    typedef logic [7:0] radiusT;

    typedef logic [1:0] directionT;

    typedef logic [1:0] colorT;

    localparam directionT dirUp    = 2'd0;
    localparam directionT dirDown  = 2'd1;
    localparam directionT dirLeft  = 2'd2;
    localparam directionT dirRight = 2'd3;

    localparam colorT colorBackground = 2'd0;
    localparam colorT colorBullet     = 2'd1;

    // Playable area, bounds inclusive
    localparam coordT arenaMinX = 10'd16;
    localparam coordT arenaMaxX = 10'd623;
    localparam coordT arenaMinY = 10'd16;
    localparam coordT arenaMaxY = 10'd463;

    // Off-screen spot for a dead bullet
    localparam coordT parkX = 10'd100;
    localparam coordT parkY = 10'd1000;

endpackage

`default_nettype wire

//--- source/BulletStartPos.sv
`timescale 1ns/1ns
`default_nettype none

module BulletStartPos (
    input  tankPkg::directionT tankDir,
    input  tankPkg::coordT     tankX,
    input  tankPkg::coordT     tankY,
    input  tankPkg::radiusT    tankRadius,
    input  tankPkg::radiusT    bulletRadius,
    output tankPkg::coordT     startX,
    output tankPkg::coordT     startY
);

    tankPkg::coordT offset;

    // Just clear of the tank body
    assign offset = tankPkg::coordT'(tankRadius) + tankPkg::coordT'(bulletRadius)
                  + tankPkg::coordT'(1);

    always_comb begin
        startX = tankX;
        startY = tankY;
        case (tankDir)
            tankPkg::dirUp: begin
                startY = tankY - offset;
            end
            tankPkg::dirDown: begin
                startY = tankY + offset;
            end
            tankPkg::dirLeft: begin
                startX = tankX - offset;
            end
            tankPkg::dirRight: begin
                startX = tankX + offset;
            end
            default: begin
                startX = tankX;
                startY = tankY;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/ArenaEdgeDetect.sv
`timescale 1ns/1ns
`default_nettype none

module ArenaEdgeDetect (
    input  tankPkg::coordT  posX,
    input  tankPkg::coordT  posY,
    input  tankPkg::radiusT radius,
    output logic            collide
);

    tankPkg::coordT lowX;
    tankPkg::coordT highX;
    tankPkg::coordT lowY;
    tankPkg::coordT highY;

    // Bounds pulled inward by the radius
    assign lowX  = tankPkg::arenaMinX + tankPkg::coordT'(radius);
    assign highX = tankPkg::arenaMaxX - tankPkg::coordT'(radius);
    assign lowY  = tankPkg::arenaMinY + tankPkg::coordT'(radius);
    assign highY = tankPkg::arenaMaxY - tankPkg::coordT'(radius);

    // A wrapped position lands above the high bound and still counts
    assign collide = (posX < lowX) || (posX > highX)
                  || (posY < lowY) || (posY > highY);

endmodule

`default_nettype wire

//--- source/BulletMapper.sv
`timescale 1ns/1ns
`default_nettype none

module BulletMapper (
    input  tankPkg::coordT  bulletX,
    input  tankPkg::coordT  bulletY,
    input  tankPkg::coordT  pixelX,
    input  tankPkg::coordT  pixelY,
    input  tankPkg::radiusT bulletRadius,
    input  logic            bulletExists,
    output tankPkg::colorT  bulletColor
);

    // One extra bit so the widened bounds never wrap
    logic [10:0] pixelXWide;
    logic [10:0] pixelYWide;
    logic [10:0] bulletXWide;
    logic [10:0] bulletYWide;
    logic        insideX;
    logic        insideY;

    assign pixelXWide  = {1'b0, pixelX} + {3'b000, bulletRadius};
    assign pixelYWide  = {1'b0, pixelY} + {3'b000, bulletRadius};
    assign bulletXWide = {1'b0, bulletX} + {3'b000, bulletRadius};
    assign bulletYWide = {1'b0, bulletY} + {3'b000, bulletRadius};

    assign insideX = ({1'b0, bulletX} <= pixelXWide) && ({1'b0, pixelX} <= bulletXWide);
    assign insideY = ({1'b0, bulletY} <= pixelYWide) && ({1'b0, pixelY} <= bulletYWide);

    assign bulletColor = (bulletExists && insideX && insideY) ? tankPkg::colorBullet
                                                              : tankPkg::colorBackground;

endmodule

`default_nettype wire

//--- source/BulletEntity.sv
`timescale 1ns/1ns
`default_nettype none

module BulletEntity (
    input  logic               frameClk,
    input  logic               reset,
    input  logic               spawn,
    input  logic               kill,
    input  logic               bounce,
    input  tankPkg::directionT startDir,
    input  tankPkg::coordT     startX,
    input  tankPkg::coordT     startY,
    input  tankPkg::radiusT    bulletStep,
    input  tankPkg::radiusT    bulletLife,
    output logic               bulletExists,
    output tankPkg::coordT     bulletX,
    output tankPkg::coordT     bulletY,
    output tankPkg::coordT     nextX,
    output tankPkg::coordT     nextY
);

    typedef enum logic [1:0] {DEAD, SPAWNED, MOVING, BOUNCE} stateT;

    stateT              state;
    stateT              nextState;
    tankPkg::directionT bulletDir;
    tankPkg::directionT reverseDir;
    tankPkg::directionT nextDir;
    tankPkg::radiusT    bounceCount;
    logic [8:0]         bounceTotal;
    logic               overLimit;
    tankPkg::coordT     step;

    assign bulletExists = (state != DEAD);

    assign bounceTotal = {1'b0, bounceCount} + 9'd1;
    assign overLimit   = bounceTotal > {1'b0, bulletLife};

    always_comb begin
        nextState = state;
        case (state)
            DEAD: begin
                if (spawn) begin
                    nextState = SPAWNED;
                end
            end
            SPAWNED: begin
                nextState = MOVING;
            end
            MOVING: begin
                // Kill takes priority
                if (kill) begin
                    nextState = DEAD;
                end else if (bounce) begin
                    nextState = BOUNCE;
                end
            end
            BOUNCE: begin
                nextState = overLimit ? DEAD : MOVING;
            end
            default: begin
                nextState = DEAD;
            end
        endcase
    end

    always_ff @(posedge frameClk) begin
        if (reset) begin
            state <= DEAD;
        end else begin
            state <= nextState;
        end
    end

    // Advanced position, one step along the current facing
    assign step = tankPkg::coordT'(bulletStep);

    always_comb begin
        nextX = bulletX;
        nextY = bulletY;
        case (bulletDir)
            tankPkg::dirUp:    nextY = bulletY - step;
            tankPkg::dirDown:  nextY = bulletY + step;
            tankPkg::dirLeft:  nextX = bulletX - step;
            tankPkg::dirRight: nextX = bulletX + step;
            default:           nextX = bulletX;
        endcase
    end

    always_ff @(posedge frameClk) begin
        if (reset) begin
            bulletX <= '0;
            bulletY <= '0;
        end else if (state == SPAWNED) begin
            bulletX <= startX;
            bulletY <= startY;
        end else if (state == DEAD) begin
            bulletX <= tankPkg::parkX;
            bulletY <= tankPkg::parkY;
        end else begin
            bulletX <= nextX;
            bulletY <= nextY;
        end
    end

    always_comb begin
        case (bulletDir)
            tankPkg::dirUp:    reverseDir = tankPkg::dirDown;
            tankPkg::dirDown:  reverseDir = tankPkg::dirUp;
            tankPkg::dirLeft:  reverseDir = tankPkg::dirRight;
            default:           reverseDir = tankPkg::dirLeft;
        endcase
    end

    always_comb begin
        nextDir = bulletDir;
        if (state == SPAWNED) begin
            nextDir = startDir;
        end else if (state == BOUNCE && !overLimit) begin
            nextDir = reverseDir;
        end
    end

    always_ff @(posedge frameClk) begin
        if (reset) begin
            bulletDir   <= tankPkg::dirRight;
            bounceCount <= '0;
        end else begin
            bulletDir <= nextDir;
            if (state == DEAD || state == SPAWNED) begin
                bounceCount <= '0;
            end else if (state == BOUNCE) begin
                bounceCount <= bounceTotal[7:0];
            end
        end
    end

    spawnedThenMoving: assert property (@(posedge frameClk) disable iff (reset)
        state == SPAWNED |=> state == MOVING);

    // Facing only turns at launch or at a bounce
    dirStableElsewhere: assert property (@(posedge frameClk) disable iff (reset)
        (state != SPAWNED && state != BOUNCE) |=> $stable(bulletDir));

    deadIsParked: assert property (@(posedge frameClk) disable iff (reset)
        state == DEAD |=> (bulletX == tankPkg::parkX && bulletY == tankPkg::parkY));

endmodule

`default_nettype wire

//--- source/Bullet.sv
`timescale 1ns/1ns
`default_nettype none

module Bullet (
    input  logic               frameClk,
    input  logic               reset,
    input  logic               fire,
    input  logic               kill,
    input  logic               bounce,
    input  tankPkg::directionT startDir,
    input  tankPkg::coordT     startX,
    input  tankPkg::coordT     startY,
    input  tankPkg::radiusT    bulletRadius,
    input  tankPkg::radiusT    bulletStep,
    input  tankPkg::radiusT    bulletLife,
    input  tankPkg::coordT     pixelX,
    input  tankPkg::coordT     pixelY,
    output logic               bulletExists,
    output tankPkg::coordT     bulletX,
    output tankPkg::coordT     bulletY,
    output tankPkg::colorT     bulletColor
);

    logic           edgeHit;
    logic           entityKill;
    tankPkg::coordT nextX;
    tankPkg::coordT nextY;

    // Leaving the arena counts as a kill
    assign entityKill = edgeHit | kill;

    BulletEntity bulletEntity (
        .frameClk     (frameClk),
        .reset        (reset),
        .spawn        (fire),
        .kill         (entityKill),
        .bounce       (bounce),
        .startDir     (startDir),
        .startX       (startX),
        .startY       (startY),
        .bulletStep   (bulletStep),
        .bulletLife   (bulletLife),
        .bulletExists (bulletExists),
        .bulletX      (bulletX),
        .bulletY      (bulletY),
        .nextX        (nextX),
        .nextY        (nextY)
    );

    ArenaEdgeDetect edgeDetect (
        .posX    (nextX),
        .posY    (nextY),
        .radius  (bulletRadius),
        .collide (edgeHit)
    );

    BulletMapper bulletMapper (
        .bulletX      (bulletX),
        .bulletY      (bulletY),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .bulletRadius (bulletRadius),
        .bulletExists (bulletExists),
        .bulletColor  (bulletColor)
    );

endmodule

`default_nettype wire

//--- source/TankGun.sv
`timescale 1ns/1ns
`default_nettype none

module TankGun (
    input  logic               frameClk,
    input  logic               reset,
    input  logic               fire,
    input  logic               bounce,
    input  logic               kill,
    input  tankPkg::coordT     tankX,
    input  tankPkg::coordT     tankY,
    input  tankPkg::directionT tankDir,
    input  tankPkg::radiusT    tankRadius,
    input  tankPkg::radiusT    bulletRadius,
    input  tankPkg::radiusT    bulletStep,
    input  tankPkg::radiusT    bulletLife,
    input  tankPkg::coordT     pixelX,
    input  tankPkg::coordT     pixelY,
    output logic               bulletExists,
    output tankPkg::coordT     bulletX,
    output tankPkg::coordT     bulletY,
    output tankPkg::colorT     bulletColor
);

    tankPkg::coordT startX;
    tankPkg::coordT startY;

    BulletStartPos startPos (
        .tankDir      (tankDir),
        .tankX        (tankX),
        .tankY        (tankY),
        .tankRadius   (tankRadius),
        .bulletRadius (bulletRadius),
        .startX       (startX),
        .startY       (startY)
    );

    Bullet bullet (
        .frameClk     (frameClk),
        .reset        (reset),
        .fire         (fire),
        .kill         (kill),
        .bounce       (bounce),
        .startDir     (tankDir),
        .startX       (startX),
        .startY       (startY),
        .bulletRadius (bulletRadius),
        .bulletStep   (bulletStep),
        .bulletLife   (bulletLife),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .bulletExists (bulletExists),
        .bulletX      (bulletX),
        .bulletY      (bulletY),
        .bulletColor  (bulletColor)
    );

endmodule

`default_nettype wire

//--- bench/TankGunBench.sv
`timescale 1ns/1ns
`default_nettype none

module TankGunBench;

    localparam int fieldCount = 13;
    localparam int maxLines   = 128;

    localparam logic [15:0] cmdStep   = 16'h0001;
    localparam logic [15:0] cmdConfig = 16'h0002;
    localparam logic [15:0] cmdWait   = 16'h0003;
    localparam logic [15:0] cmdEnd    = 16'h000F;
    localparam logic [15:0] dontCare  = 16'hFFFF;

    logic               frameClk;
    logic               reset;
    logic               fire;
    logic               bounce;
    logic               kill;
    tankPkg::coordT     tankX;
    tankPkg::coordT     tankY;
    tankPkg::directionT tankDir;
    tankPkg::radiusT    tankRadius;
    tankPkg::radiusT    bulletRadius;
    tankPkg::radiusT    bulletStep;
    tankPkg::radiusT    bulletLife;
    tankPkg::coordT     pixelX;
    tankPkg::coordT     pixelY;
    logic               bulletExists;
    tankPkg::coordT     bulletX;
    tankPkg::coordT     bulletY;
    tankPkg::colorT     bulletColor;

    // One test line is fieldCount words
    logic [15:0] testMem [0:fieldCount*maxLines-1];

    int checkCount;
    int errorCount;

    TankGun u_TankGun (
        .frameClk     (frameClk),
        .reset        (reset),
        .fire         (fire),
        .bounce       (bounce),
        .kill         (kill),
        .tankX        (tankX),
        .tankY        (tankY),
        .tankDir      (tankDir),
        .tankRadius   (tankRadius),
        .bulletRadius (bulletRadius),
        .bulletStep   (bulletStep),
        .bulletLife   (bulletLife),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .bulletExists (bulletExists),
        .bulletX      (bulletX),
        .bulletY      (bulletY),
        .bulletColor  (bulletColor)
    );

    initial begin
        frameClk = 1'b0;
        forever begin
            #50 frameClk = ~frameClk;
        end
    end

    // Marker entries in the test file are skipped
    task automatic compareValue(input string name, input logic [15:0] actual,
                                input logic [15:0] expected, input int stepNo);
        if (expected != dontCare) begin
            checkCount = checkCount + 1;
            if (actual !== expected) begin
                errorCount = errorCount + 1;
                $display("ERROR %s: got 0x%0h, expected 0x%0h (test line %0d)",
                         name, actual, expected, stepNo);
            end
        end
    endtask

    task automatic applyConfig(input int base);
        tankRadius   = testMem[base + 1][7:0];
        bulletRadius = testMem[base + 2][7:0];
        bulletStep   = testMem[base + 3][7:0];
        bulletLife   = testMem[base + 4][7:0];
    endtask

    // Drive one line, then check the state after the next edge
    task automatic applyStep(input int base, input int stepNo);
        fire    = testMem[base + 1][0];
        bounce  = testMem[base + 2][0];
        kill    = testMem[base + 3][0];
        tankX   = testMem[base + 4][9:0];
        tankY   = testMem[base + 5][9:0];
        tankDir = testMem[base + 6][1:0];
        pixelX  = testMem[base + 7][9:0];
        pixelY  = testMem[base + 8][9:0];
        @(posedge frameClk);
        #5;
        compareValue("bulletExists", {15'd0, bulletExists}, testMem[base + 9], stepNo);
        compareValue("bulletX", {6'd0, bulletX}, testMem[base + 10], stepNo);
        compareValue("bulletY", {6'd0, bulletY}, testMem[base + 11], stepNo);
        compareValue("bulletColor", {14'd0, bulletColor}, testMem[base + 12], stepNo);
    endtask

    task automatic waitForDeath(input logic [15:0] limit, input int stepNo);
        logic [15:0] cycles;
        logic        dead;
        cycles = 16'd0;
        dead   = 1'b0;
        fire   = 1'b0;
        bounce = 1'b0;
        kill   = 1'b0;
        while (!dead && cycles < limit) begin
            @(posedge frameClk);
            #5;
            dead   = !bulletExists;
            cycles = cycles + 16'd1;
        end
        if (!dead) begin
            errorCount = errorCount + 1;
            $display("Test line %0d: bullet still alive after %0d frames", stepNo, limit);
        end
    endtask

    initial begin
        int          lineNo;
        int          base;
        logic        finished;
        logic [15:0] cmd;
        reset        = 1'b1;
        fire         = 1'b0;
        bounce       = 1'b0;
        kill         = 1'b0;
        tankX        = '0;
        tankY        = '0;
        tankDir      = tankPkg::dirUp;
        tankRadius   = '0;
        bulletRadius = '0;
        bulletStep   = '0;
        bulletLife   = '0;
        pixelX       = '0;
        pixelY       = '0;
        checkCount   = 0;
        errorCount   = 0;
        $readmemh("bench/bulletTests.txt", testMem);

        repeat (4) @(posedge frameClk);
        #5;
        reset = 1'b0;

        finished = 1'b0;
        lineNo   = 0;
        while (!finished && lineNo < maxLines) begin
            base = lineNo * fieldCount;
            cmd  = testMem[base];
            case (cmd)
                cmdStep: begin
                    applyStep(base, lineNo);
                end
                cmdConfig: begin
                    applyConfig(base);
                end
                cmdWait: begin
                    waitForDeath(testMem[base + 1], lineNo);
                end
                cmdEnd: begin
                    finished = 1'b1;
                end
                default: begin
                    errorCount = errorCount + 1;
                    $display("Test line %0d: unknown command 0x%0h in test file", lineNo, cmd);
                    finished = 1'b1;
                end
            endcase
            lineNo = lineNo + 1;
        end
        if (!finished) begin
            errorCount = errorCount + 1;
            $display("Test file has no end line");
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/bulletTests.txt
// cmd fire bounce kill tankX tankY dir pixX pixY | exists X Y color, all hex, FFFF = don't care
// cmd 1 step, 2 config (tankRadius bulletRadius step life), 3 wait for death (limit), F end
2 010 004 008 002 000 000 000 000 0000 0000 0000 0000
// After reset: parked and invisible
1 0 0 0 140 0F0 0 064 3E8 0 064 3E8 0
1 0 0 0 140 0F0 0 000 000 0 064 3E8 0
// Facing up, start 21 above the tank
1 1 0 0 140 0F0 0 140 0DB 1 064 3E8 FFFF
1 0 0 0 140 0F0 0 140 0DB 1 140 0DB 1
1 0 0 0 140 0F0 0 144 0CF 1 140 0D3 1
1 0 0 1 140 0F0 0 140 0CB 0 140 0CB 0
1 0 0 0 140 0F0 0 140 0CB 0 064 3E8 0
// Facing down
1 1 0 0 140 0F0 1 000 000 1 064 3E8 0
1 0 0 0 140 0F0 1 140 109 1 140 105 1
1 0 0 0 140 0F0 1 140 112 1 140 10D 0
1 0 0 1 140 0F0 1 140 115 0 140 115 0
1 0 0 0 140 0F0 1 000 000 0 064 3E8 0
// Facing left, with pixel probes
1 1 0 0 140 0F0 2 000 000 1 064 3E8 0
1 0 0 0 140 0F0 2 12B 0F0 1 12B 0F0 1
1 0 0 0 140 0F0 2 11F 0EC 1 123 0F0 1
1 0 0 0 140 0F0 2 11B 0F0 1 11B 0F0 1
1 0 0 0 140 0F0 2 118 0F0 1 113 0F0 0
1 0 0 0 140 0F0 2 107 0F5 1 10B 0F0 0
1 0 0 1 140 0F0 2 000 000 0 103 0F0 0
1 0 0 0 140 0F0 2 000 000 0 064 3E8 0
// Facing right into the arena edge
1 1 0 0 230 0F0 3 000 000 1 064 3E8 0
1 0 0 0 230 0F0 3 000 000 1 245 0F0 0
1 0 0 0 230 0F0 3 251 0F0 1 24D 0F0 1
1 0 0 0 230 0F0 3 000 000 1 255 0F0 0
1 0 0 0 230 0F0 3 000 000 1 25D 0F0 0
1 0 0 0 230 0F0 3 269 0F0 1 265 0F0 1
1 0 0 0 230 0F0 3 26D 0F0 0 26D 0F0 0
1 0 0 0 230 0F0 3 000 000 0 064 3E8 0
// Bounces with a life of 2, the third one kills
1 1 0 0 140 0F0 3 000 000 1 064 3E8 0
1 0 0 0 140 0F0 3 000 000 1 155 0F0 0
1 0 0 0 140 0F0 3 000 000 1 15D 0F0 0
1 0 1 0 140 0F0 3 000 000 1 165 0F0 0
1 0 0 0 140 0F0 3 171 0F0 1 16D 0F0 1
1 0 0 0 140 0F0 3 000 000 1 165 0F0 0
1 0 0 0 140 0F0 3 000 000 1 15D 0F0 0
1 0 1 0 140 0F0 3 000 000 1 155 0F0 0
1 0 0 0 140 0F0 3 000 000 1 14D 0F0 0
1 0 0 0 140 0F0 3 000 000 1 155 0F0 0
1 0 1 0 140 0F0 3 000 000 1 15D 0F0 FFFF
1 0 0 0 140 0F0 3 000 000 0 165 0F0 0
1 0 0 0 140 0F0 3 000 000 0 064 3E8 0
// Fire and tankDir ignored in flight, kill beats bounce
1 1 0 0 140 0F0 0 000 000 1 064 3E8 0
1 0 0 0 140 0F0 0 000 000 1 140 0DB 0
1 0 0 0 140 0F0 0 000 000 1 140 0D3 0
1 1 0 0 140 0F0 0 000 000 1 140 0CB 0
1 0 0 0 140 0F0 3 000 000 1 140 0C3 0
1 1 0 0 140 0F0 3 000 000 1 140 0BB 0
1 0 1 1 140 0F0 3 000 000 0 140 0B3 0
1 0 0 0 140 0F0 3 000 000 0 064 3E8 0
// Edge death found by waiting
1 1 0 0 230 0F0 3 000 000 1 064 3E8 0
3 00A 000 000 000 000 000 000 000 0000 0000 0000 0000
1 0 0 0 230 0F0 3 000 000 0 064 3E8 0
// Life of 0, first bounce kills
2 010 004 008 000 000 000 000 000 0000 0000 0000 0000
1 1 0 0 140 0F0 0 000 000 1 064 3E8 0
1 0 0 0 140 0F0 0 000 000 1 140 0DB 0
1 0 1 0 140 0F0 0 000 000 1 140 0D3 0
3 00A 000 000 000 000 000 000 000 0000 0000 0000 0000
1 0 0 0 140 0F0 0 000 000 0 064 3E8 0
F 000 000 000 000 000 000 000 000 0000 0000 0000 0000

//--- verilog.f
source/tankPkg.sv
source/BulletStartPos.sv
source/ArenaEdgeDetect.sv
source/BulletMapper.sv
source/BulletEntity.sv
source/Bullet.sv
source/TankGun.sv
bench/TankGunBench.sv

//--- Makefile
# Verilator build and run for the TankGun bullet subsystem

VERILATOR  ?= verilator
TOP        ?= TankGunBench
RTL_TOP    ?= TankGun
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
SIM        ?= $(BUILD_DIR)/V$(TOP)
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only if the simulation prints the pass line
run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
